/* Bender.yml */
package:
  name: apb_periph

sources:
  - include_dirs:
      - design
    files:
      - design/apb_periph_pkg.sv
      - design/apb_periph_decode.sv
      - design/gpio_ctrl.sv
      - design/soc_ctrl_regs.sv
      - design/pwm_cfg_regs.sv
      - design/pwm_gen.sv
      - design/apb_periph_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/apb_periph_sva.sv
      - bench/apb_periph_checker.sv
      - bench/apb_periph_tb.sv

/* apb_periph_top.f */
+incdir+design
design/apb_periph_pkg.sv
design/apb_periph_decode.sv
design/gpio_ctrl.sv
design/soc_ctrl_regs.sv
design/pwm_cfg_regs.sv
design/pwm_gen.sv
design/apb_periph_top.sv
bench/apb_periph_sva.sv
bench/apb_periph_checker.sv
bench/apb_periph_tb.sv

/* bench/apb_periph_checker.sv */
// Register model sampled at the falling edge; IN is checked only after the pads held for 3 clocks
`include "apb_periph_settings.svh"

module apb_periph_checker (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  apb_periph_pkg::apb_addr_t       paddr_i,
   input  apb_periph_pkg::apb_data_t       pwdata_i,
   input  apb_periph_pkg::apb_data_t       prdata_i,
   input  logic                            pready_i,
   input  logic                            pslverr_i,
   input  logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_in_i,
   input  logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_out_i,
   input  logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_oe_i,
   input  logic                            cluster_rstn_i,
   input  logic                            sa_boot_i,
   input  logic                            fetch_en_i,
   input  apb_periph_pkg::apb_addr_t       boot_addr_i,
   input  logic [`APB_PERIPH_PWM_CH-1:0]   pwm_i,
   output int                              err_cnt_o,
   output int                              pwm_windows_o
);

   logic [`APB_PERIPH_GPIO_NUM-1:0] m_out;
   logic [`APB_PERIPH_GPIO_NUM-1:0] m_dir;
   logic [2:0]                      m_ctrl;
   logic [31:0]                     m_boot;
   logic                            m_en;
   logic [7:0]                      m_pre;
   logic [15:0]                     m_period;
   logic [15:0]                     m_thr [`APB_PERIPH_PWM_CH];
   logic [`APB_PERIPH_GPIO_NUM-1:0] in_last;
   int                              in_stable;
   int                              pwm_quiet;
   logic                            win_active;
   int                              win_cnt;
   int                              win_high [`APB_PERIPH_PWM_CH];

   initial begin
      err_cnt_o     = 0;
      pwm_windows_o = 0;
   end

   task automatic compare_value(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
      if (act !== exp) begin
         $display("FAIL t=%0t %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
         err_cnt_o++;
      end
   endtask

   function automatic logic [31:0] read_model(input logic [3:0] sel, input logic [2:0] idx);
      logic [31:0] rd;
      rd = '0;
      case (sel)
         4'd0: begin
            if (idx == 3'd0) rd = m_out;
            if (idx == 3'd1) rd = m_dir;
            if (idx == 3'd2) rd = in_last;
         end
         4'd1: begin
            if (idx == 3'd0) rd = {29'h0, m_ctrl};
            if (idx == 3'd1) rd = m_boot;
         end
         4'd2: begin
            if (idx == 3'd0) rd = {16'h0, m_pre, 7'h0, m_en};
            if (idx == 3'd1) rd = {16'h0, m_period};
            if (idx >= 3'd2 && idx <= 3'd5) rd = {16'h0, m_thr[idx - 2]};
         end
         default: rd = '0;
      endcase
      return rd;
   endfunction

   task automatic write_model(input logic [3:0] sel, input logic [2:0] idx,
                              input logic [31:0] d);
      case (sel)
         4'd0: begin
            if (idx == 3'd0) m_out = d;
            if (idx == 3'd1) m_dir = d;
         end
         4'd1: begin
            if (idx == 3'd0) m_ctrl = d[2:0];
            if (idx == 3'd1) m_boot = d;
         end
         4'd2: begin
            if (idx == 3'd0) begin
               m_en  = d[0];
               m_pre = d[15:8];
            end
            if (idx == 3'd1) m_period = d[15:0];
            if (idx >= 3'd2 && idx <= 3'd5) m_thr[idx - 2] = d[15:0];
            // Counter may run off its steady pattern for up to one period
            pwm_quiet  = 0;
            win_active = 1'b0;
         end
         default: ;
      endcase
   endtask

   // High time per channel over one full PWM period at any phase
   task automatic check_pwm();
      int len;
      int hi;
      len = (int'(m_period) + 1) * (int'(m_pre) + 1);
      if (!m_en) begin
         win_active = 1'b0;
         if (pwm_quiet >= 2) compare_value("pwm_o", '0, pwm_i);
      end else begin
         if (!win_active && pwm_quiet > len + 2) begin
            win_active = 1'b1;
            win_cnt    = 0;
            for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) win_high[k] = 0;
         end
         if (win_active) begin
            for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) begin
               if (pwm_i[k]) win_high[k]++;
            end
            win_cnt++;
            if (win_cnt == len) begin
               for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) begin
                  hi = int'(m_thr[k]);
                  if (hi > int'(m_period) + 1) hi = int'(m_period) + 1;
                  compare_value($sformatf("pwm_o[%0d] high cycles", k),
                                hi * (int'(m_pre) + 1), win_high[k]);
               end
               pwm_windows_o++;
               win_active = 1'b0;
            end
         end
      end
   endtask

   always @(negedge clk_i) begin
      logic [3:0] sel;
      logic [2:0] idx;
      if (!arst_n_i) begin
         m_out      = '0;
         m_dir      = '0;
         m_ctrl     = '0;
         m_boot     = `APB_PERIPH_BOOT_ADDR_RST;
         m_en       = 1'b0;
         m_pre      = '0;
         m_period   = '0;
         for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) m_thr[k] = '0;
         in_last    = '0;
         in_stable  = 0;
         pwm_quiet  = 0;
         win_active = 1'b0;
      end else begin
         if (gpio_in_i !== in_last) begin
            in_last   = gpio_in_i;
            in_stable = 0;
         end else if (in_stable < 1000) begin
            in_stable++;
         end
         compare_value("gpio_out_o", m_out, gpio_out_i);
         compare_value("gpio_oe_o", m_dir, gpio_oe_i);
         compare_value("cluster_rstn_o", m_ctrl[0], cluster_rstn_i);
         compare_value("cluster_en_sa_boot_o", m_ctrl[1], sa_boot_i);
         compare_value("cluster_fetch_en_o", m_ctrl[2], fetch_en_i);
         compare_value("cluster_boot_addr_o", m_boot, boot_addr_i);
         check_pwm();
         if (psel_i && penable_i) begin
            sel = paddr_i[`APB_PERIPH_SEL_MSB:`APB_PERIPH_SEL_LSB];
            idx = paddr_i[`APB_PERIPH_REG_MSB:`APB_PERIPH_REG_LSB];
            compare_value("pready_o", 1'b1, pready_i);
            compare_value("pslverr_o", sel > 4'd2, pslverr_i);
            if (pwrite_i) begin
               write_model(sel, idx, pwdata_i);
            end else if (sel != 4'd0 || idx != 3'd2 || in_stable >= 3) begin
               compare_value("prdata_o", read_model(sel, idx), prdata_i);
            end
         end else begin
            compare_value("pslverr_o", 1'b0, pslverr_i);
         end
         if (pwm_quiet < 1000000) pwm_quiet++;
      end
   end

endmodule

/* bench/apb_periph_sva.sv */
// Bound into apb_periph_top; assumes psel_i stays low while reset is held
`include "apb_periph_settings.svh"

module apb_periph_sva (
   input logic                            clk_i,
   input logic                            arst_n_i,
   input logic                            psel_i,
   input logic                            penable_i,
   input logic                            pready_i,
   input logic                            pslverr_i,
   input logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_out_i,
   input logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_oe_i,
   input logic                            cluster_rstn_i,
   input logic                            sa_boot_i,
   input logic                            fetch_en_i,
   input logic [`APB_PERIPH_PWM_CH-1:0]   pwm_i
);

   int fail_cnt;

   initial fail_cnt = 0;

   // Zero wait states
   ready_in_access: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) (psel_i && penable_i) |-> pready_i)
      else begin
         $error("pready_o low in an access cycle");
         fail_cnt++;
      end

   err_only_in_access: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) !(psel_i && penable_i) |-> !pslverr_i)
      else begin
         $error("pslverr_o high outside an access cycle");
         fail_cnt++;
      end

   // Sampled mid cycle so the asynchronous reset has settled
   low_in_reset: assert property (
      @(negedge clk_i) !arst_n_i |-> (gpio_out_i == '0 && gpio_oe_i == '0 && !cluster_rstn_i
         && !sa_boot_i && !fetch_en_i && pwm_i == '0 && !pslverr_i))
      else begin
         $error("outputs not low during reset");
         fail_cnt++;
      end

endmodule

bind apb_periph_top apb_periph_sva u_sva (
   .clk_i          ( clk_i                ),
   .arst_n_i       ( arst_n_i             ),
   .psel_i         ( psel_i               ),
   .penable_i      ( penable_i            ),
   .pready_i       ( pready_o             ),
   .pslverr_i      ( pslverr_o            ),
   .gpio_out_i     ( gpio_out_o           ),
   .gpio_oe_i      ( gpio_oe_o            ),
   .cluster_rstn_i ( cluster_rstn_o       ),
   .sa_boot_i      ( cluster_en_sa_boot_o ),
   .fetch_en_i     ( cluster_fetch_en_o   ),
   .pwm_i          ( pwm_o                )
);

/* bench/apb_periph_tb.sv */
// Fixed seed random APB traffic, then PWM configs with prescale below 4 and period below 16
`include "apb_periph_settings.svh"

module apb_periph_tb;

   localparam int CLK_PERIOD  = 20;
   localparam int NUM_XFER    = 300;
   localparam int NUM_PWM_CFG = 6;
   // Enough clocks to settle and measure one window at the largest PWM period
   localparam int PWM_WAIT    = 200;
   localparam int RUN_CYCLES  = NUM_XFER * 3 + NUM_PWM_CFG * (PWM_WAIT + 6 * 3) + 20;
   localparam int WATCHDOG    = 2 * RUN_CYCLES * CLK_PERIOD;

   logic                            clk;
   logic                            arst_n;
   logic                            psel;
   logic                            penable;
   logic                            pwrite;
   apb_periph_pkg::apb_addr_t       paddr;
   apb_periph_pkg::apb_data_t       pwdata;
   apb_periph_pkg::apb_data_t       prdata;
   logic                            pready;
   logic                            pslverr;
   logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_in;
   logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_out;
   logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_oe;
   logic                            cluster_rstn;
   logic                            sa_boot;
   logic                            fetch_en;
   apb_periph_pkg::apb_addr_t       boot_addr;
   logic [`APB_PERIPH_PWM_CH-1:0]   pwm;
   int                              seed;
   int                              err_cnt;
   int                              pwm_windows;
   int                              total_err;

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   apb_periph_top u_dut (
      .clk_i                ( clk          ),
      .arst_n_i             ( arst_n       ),
      .psel_i               ( psel         ),
      .penable_i            ( penable      ),
      .pwrite_i             ( pwrite       ),
      .paddr_i              ( paddr        ),
      .pwdata_i             ( pwdata       ),
      .prdata_o             ( prdata       ),
      .pready_o             ( pready       ),
      .pslverr_o            ( pslverr      ),
      .gpio_in_i            ( gpio_in      ),
      .gpio_out_o           ( gpio_out     ),
      .gpio_oe_o            ( gpio_oe      ),
      .cluster_rstn_o       ( cluster_rstn ),
      .cluster_en_sa_boot_o ( sa_boot      ),
      .cluster_fetch_en_o   ( fetch_en     ),
      .cluster_boot_addr_o  ( boot_addr    ),
      .pwm_o                ( pwm          )
   );

   apb_periph_checker u_chk (
      .clk_i          ( clk          ),
      .arst_n_i       ( arst_n       ),
      .psel_i         ( psel         ),
      .penable_i      ( penable      ),
      .pwrite_i       ( pwrite       ),
      .paddr_i        ( paddr        ),
      .pwdata_i       ( pwdata       ),
      .prdata_i       ( prdata       ),
      .pready_i       ( pready       ),
      .pslverr_i      ( pslverr      ),
      .gpio_in_i      ( gpio_in      ),
      .gpio_out_i     ( gpio_out     ),
      .gpio_oe_i      ( gpio_oe      ),
      .cluster_rstn_i ( cluster_rstn ),
      .sa_boot_i      ( sa_boot      ),
      .fetch_en_i     ( fetch_en     ),
      .boot_addr_i    ( boot_addr    ),
      .pwm_i          ( pwm          ),
      .err_cnt_o      ( err_cnt      ),
      .pwm_windows_o  ( pwm_windows  )
   );

   function automatic apb_periph_pkg::apb_addr_t make_addr(input logic [3:0] sel,
                                                          input logic [2:0] idx);
      apb_periph_pkg::apb_addr_t a;
      a = '0;
      a[`APB_PERIPH_SEL_MSB:`APB_PERIPH_SEL_LSB] = sel;
      a[`APB_PERIPH_REG_MSB:`APB_PERIPH_REG_LSB] = idx;
      return a;
   endfunction

   task automatic idle_cycles(input int n);
      repeat (n) @(posedge clk);
      #2;
   endtask

   // Setup, access, then one idle cycle
   task automatic apb_xfer(input logic wr, input apb_periph_pkg::apb_addr_t addr,
                           input apb_periph_pkg::apb_data_t data);
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      idle_cycles(1);
      penable = 1'b1;
      idle_cycles(1);
      psel    = 1'b0;
      penable = 1'b0;
      idle_cycles(1);
   endtask

   task automatic random_xfer();
      logic [3:0]                sel;
      logic [2:0]                idx;
      logic                      wr;
      apb_periph_pkg::apb_data_t data;
      sel = 4'($unsigned($random(seed)) % 16);
      // Mostly the three mapped peripherals with 12 to 15 left unmapped
      if (sel < 4'd12) sel = 4'(sel % 3);
      idx  = 3'($random(seed));
      wr   = 1'($random(seed));
      data = $random(seed);
      if (($unsigned($random(seed)) % 8) == 0) gpio_in = $random(seed);
      apb_xfer(wr, make_addr(sel, idx), data);
   endtask

   task automatic pwm_config(input logic en);
      logic [7:0]  pre;
      logic [15:0] val;
      pre = 8'($unsigned($random(seed)) % 4);
      val = 16'($unsigned($random(seed)) % 16);
      apb_xfer(1'b1, make_addr(4'd2, 3'd1), {16'h0, val});
      for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) begin
         val = 16'($unsigned($random(seed)) % 20);
         apb_xfer(1'b1, make_addr(4'd2, 3'(k + 2)), {16'h0, val});
      end
      apb_xfer(1'b1, make_addr(4'd2, 3'd0), {16'h0, pre, 7'h0, en});
      idle_cycles(PWM_WAIT);
   endtask

   initial begin
      seed    = 68;
      arst_n  = 1'b0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = '0;
      pwdata  = '0;
      gpio_in = '0;
      idle_cycles(3);
      arst_n = 1'b1;
      // Boot address and CTRL straight out of reset
      apb_xfer(1'b0, make_addr(4'd1, 3'd1), '0);
      apb_xfer(1'b0, make_addr(4'd1, 3'd0), '0);
      for (int i = 0; i < NUM_XFER; i++) random_xfer();
      for (int c = 0; c < NUM_PWM_CFG; c++) pwm_config(c != 2);
      idle_cycles(5);
      total_err = err_cnt + u_dut.u_sva.fail_cnt;
      if (pwm_windows == 0) begin
         $display("ERROR: no PWM window was measured");
         total_err++;
      end
      $display("Run complete: %0d errors, %0d PWM windows checked", total_err, pwm_windows);
      if (total_err == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("Timeout: run did not finish within %0d time units", WATCHDOG);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

/* design/apb_periph_decode.sv */
// Combinational APB decoder with zero wait states; address bits above the select field alias
`include "apb_periph_settings.svh"

module apb_periph_decode (
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  apb_periph_pkg::apb_addr_t paddr_i,
   input  apb_periph_pkg::apb_data_t gpio_rdata_i,
   input  apb_periph_pkg::apb_data_t soc_rdata_i,
   input  apb_periph_pkg::apb_data_t pwm_rdata_i,
   output logic                      gpio_sel_o,
   output logic                      soc_sel_o,
   output logic                      pwm_sel_o,
   output apb_periph_pkg::apb_data_t prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o
);

   logic [`APB_PERIPH_SEL_MSB-`APB_PERIPH_SEL_LSB:0] sel_bits;
   apb_periph_pkg::periph_sel_e                      sel;

   assign sel_bits = paddr_i[`APB_PERIPH_SEL_MSB:`APB_PERIPH_SEL_LSB];

   always_comb begin
      case (sel_bits)
         'd0:     sel = apb_periph_pkg::SEL_GPIO;
         'd1:     sel = apb_periph_pkg::SEL_SOCCTRL;
         'd2:     sel = apb_periph_pkg::SEL_PWM;
         default: sel = apb_periph_pkg::SEL_NONE;
      endcase
   end

   // One-hot selects raised only while psel_i is high
   assign gpio_sel_o = psel_i && (sel == apb_periph_pkg::SEL_GPIO);
   assign soc_sel_o  = psel_i && (sel == apb_periph_pkg::SEL_SOCCTRL);
   assign pwm_sel_o  = psel_i && (sel == apb_periph_pkg::SEL_PWM);

   always_comb begin
      case (sel)
         apb_periph_pkg::SEL_GPIO:    prdata_o = gpio_rdata_i;
         apb_periph_pkg::SEL_SOCCTRL: prdata_o = soc_rdata_i;
         apb_periph_pkg::SEL_PWM:     prdata_o = pwm_rdata_i;
         default:                     prdata_o = '0;
      endcase
   end

   // No wait states anywhere behind the decoder
   assign pready_o = 1'b1;

   // Unmapped peripheral flagged in the access phase only
   assign pslverr_o = psel_i && penable_i && (sel == apb_periph_pkg::SEL_NONE);

endmodule

/* design/apb_periph_pkg.sv */
// Bus word, counter and select types; all widths are fixed for the whole build
`include "apb_periph_settings.svh"

package apb_periph_pkg;

   typedef logic [`APB_PERIPH_ADDR_W-1:0] apb_addr_t;
   typedef logic [`APB_PERIPH_DATA_W-1:0] apb_data_t;

   // Encodings follow the select field value and anything above 2 is unmapped
   typedef enum logic [1:0] {
      SEL_GPIO    = 2'd0,
      SEL_SOCCTRL = 2'd1,
      SEL_PWM     = 2'd2,
      SEL_NONE    = 2'd3
   } periph_sel_e;

   typedef logic [`APB_PERIPH_PWM_W-1:0] pwm_cnt_t;

endpackage

/* design/apb_periph_settings.svh */
// Fixed widths and address map for one build; the select field decodes bits 15:12 and ignores higher bits
`ifndef APB_PERIPH_SETTINGS_SVH
`define APB_PERIPH_SETTINGS_SVH

`define APB_PERIPH_ADDR_W 32
`define APB_PERIPH_DATA_W 32

// Peripheral select and register index fields of paddr
`define APB_PERIPH_SEL_MSB 15
`define APB_PERIPH_SEL_LSB 12
`define APB_PERIPH_REG_MSB 4
`define APB_PERIPH_REG_LSB 2

`define APB_PERIPH_GPIO_NUM 32
`define APB_PERIPH_PWM_CH 4
`define APB_PERIPH_PWM_W 16

`define APB_PERIPH_BOOT_ADDR_RST 32'h1C00_0000

`endif

/* design/apb_periph_top.sv */
// Single clock APB peripheral block; pready_o is always high and there are no interrupts
`include "apb_periph_settings.svh"

module apb_periph_top (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            psel_i,
   input  logic                            penable_i,
   input  logic                            pwrite_i,
   input  apb_periph_pkg::apb_addr_t       paddr_i,
   input  apb_periph_pkg::apb_data_t       pwdata_i,
   output apb_periph_pkg::apb_data_t       prdata_o,
   output logic                            pready_o,
   output logic                            pslverr_o,
   input  logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_in_i,
   output logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_out_o,
   output logic [`APB_PERIPH_GPIO_NUM-1:0] gpio_oe_o,
   output logic                            cluster_rstn_o,
   output logic                            cluster_en_sa_boot_o,
   output logic                            cluster_fetch_en_o,
   output apb_periph_pkg::apb_addr_t       cluster_boot_addr_o,
   output logic [`APB_PERIPH_PWM_CH-1:0]   pwm_o
);

   logic                                              gpio_sel;
   logic                                              soc_sel;
   logic                                              pwm_sel;
   apb_periph_pkg::apb_data_t                         gpio_rdata;
   apb_periph_pkg::apb_data_t                         soc_rdata;
   apb_periph_pkg::apb_data_t                         pwm_rdata;
   logic                                              pwm_en;
   logic [7:0]                                        pwm_prescale;
   apb_periph_pkg::pwm_cnt_t                          pwm_period;
   apb_periph_pkg::pwm_cnt_t [`APB_PERIPH_PWM_CH-1:0] pwm_threshold;

   apb_periph_decode u_decode (
      .psel_i       ( psel_i     ),
      .penable_i    ( penable_i  ),
      .paddr_i      ( paddr_i    ),
      .gpio_rdata_i ( gpio_rdata ),
      .soc_rdata_i  ( soc_rdata  ),
      .pwm_rdata_i  ( pwm_rdata  ),
      .gpio_sel_o   ( gpio_sel   ),
      .soc_sel_o    ( soc_sel    ),
      .pwm_sel_o    ( pwm_sel    ),
      .prdata_o     ( prdata_o   ),
      .pready_o     ( pready_o   ),
      .pslverr_o    ( pslverr_o  )
   );

   gpio_ctrl u_gpio (
      .clk_i      ( clk_i                                            ),
      .arst_n_i   ( arst_n_i                                         ),
      .sel_i      ( gpio_sel                                         ),
      .penable_i  ( penable_i                                        ),
      .pwrite_i   ( pwrite_i                                         ),
      .reg_idx_i  ( paddr_i[`APB_PERIPH_REG_MSB:`APB_PERIPH_REG_LSB] ),
      .wdata_i    ( pwdata_i                                         ),
      .gpio_in_i  ( gpio_in_i                                        ),
      .rdata_o    ( gpio_rdata                                       ),
      .gpio_out_o ( gpio_out_o                                       ),
      .gpio_oe_o  ( gpio_oe_o                                        )
   );

   soc_ctrl_regs u_soc_ctrl (
      .clk_i                ( clk_i                                            ),
      .arst_n_i             ( arst_n_i                                         ),
      .sel_i                ( soc_sel                                          ),
      .penable_i            ( penable_i                                        ),
      .pwrite_i             ( pwrite_i                                         ),
      .reg_idx_i            ( paddr_i[`APB_PERIPH_REG_MSB:`APB_PERIPH_REG_LSB] ),
      .wdata_i              ( pwdata_i                                         ),
      .rdata_o              ( soc_rdata                                        ),
      .cluster_rstn_o       ( cluster_rstn_o                                   ),
      .cluster_en_sa_boot_o ( cluster_en_sa_boot_o                             ),
      .cluster_fetch_en_o   ( cluster_fetch_en_o                               ),
      .cluster_boot_addr_o  ( cluster_boot_addr_o                              )
   );

   pwm_cfg_regs u_pwm_cfg (
      .clk_i       ( clk_i                                            ),
      .arst_n_i    ( arst_n_i                                         ),
      .sel_i       ( pwm_sel                                          ),
      .penable_i   ( penable_i                                        ),
      .pwrite_i    ( pwrite_i                                         ),
      .reg_idx_i   ( paddr_i[`APB_PERIPH_REG_MSB:`APB_PERIPH_REG_LSB] ),
      .wdata_i     ( pwdata_i                                         ),
      .rdata_o     ( pwm_rdata                                        ),
      .pwm_en_o    ( pwm_en                                           ),
      .prescale_o  ( pwm_prescale                                     ),
      .period_o    ( pwm_period                                       ),
      .threshold_o ( pwm_threshold                                    )
   );

   pwm_gen u_pwm_gen (
      .clk_i       ( clk_i         ),
      .arst_n_i    ( arst_n_i      ),
      .pwm_en_i    ( pwm_en        ),
      .prescale_i  ( pwm_prescale  ),
      .period_i    ( pwm_period    ),
      .threshold_i ( pwm_threshold ),
      .pwm_o       ( pwm_o         )
   );

endmodule

/* design/gpio_ctrl.sv */
// GPIO count must not exceed the APB data width; IN lags the pads by two clocks
`include "apb_periph_settings.svh"

module gpio_ctrl (
   input  logic                                             clk_i,
   input  logic                                             arst_n_i,
   input  logic                                             sel_i,
   input  logic                                             penable_i,
   input  logic                                             pwrite_i,
   input  logic [`APB_PERIPH_REG_MSB-`APB_PERIPH_REG_LSB:0] reg_idx_i,
   input  apb_periph_pkg::apb_data_t                        wdata_i,
   input  logic [`APB_PERIPH_GPIO_NUM-1:0]                  gpio_in_i,
   output apb_periph_pkg::apb_data_t                        rdata_o,
   output logic [`APB_PERIPH_GPIO_NUM-1:0]                  gpio_out_o,
   output logic [`APB_PERIPH_GPIO_NUM-1:0]                  gpio_oe_o
);

   logic                             wr_en;
   logic [`APB_PERIPH_GPIO_NUM-1:0]  in_meta_q;
   logic [`APB_PERIPH_GPIO_NUM-1:0]  in_sync_q;

   assign wr_en = sel_i && penable_i && pwrite_i;

   // OUT and DIR drive the pads directly
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         gpio_out_o <= '0;
         gpio_oe_o  <= '0;
      end else if (wr_en) begin
         if (reg_idx_i == 3'd0) begin
            gpio_out_o <= wdata_i[`APB_PERIPH_GPIO_NUM-1:0];
         end
         if (reg_idx_i == 3'd1) begin
            gpio_oe_o <= wdata_i[`APB_PERIPH_GPIO_NUM-1:0];
         end
      end
   end

   // Two-flop synchronizer for asynchronous pad inputs
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         in_meta_q <= '0;
         in_sync_q <= '0;
      end else begin
         in_meta_q <= gpio_in_i;
         in_sync_q <= in_meta_q;
      end
   end

   always_comb begin
      rdata_o = '0;
      case (reg_idx_i)
         3'd0:    rdata_o[`APB_PERIPH_GPIO_NUM-1:0] = gpio_out_o;
         3'd1:    rdata_o[`APB_PERIPH_GPIO_NUM-1:0] = gpio_oe_o;
         3'd2:    rdata_o[`APB_PERIPH_GPIO_NUM-1:0] = in_sync_q;
         default: rdata_o = '0;
      endcase
   end

endmodule

/* design/pwm_cfg_regs.sv */
// PWM configuration only; a write changes just the addressed register and never restarts the counter
`include "apb_periph_settings.svh"

module pwm_cfg_regs (
   input  logic                                             clk_i,
   input  logic                                             arst_n_i,
   input  logic                                             sel_i,
   input  logic                                             penable_i,
   input  logic                                             pwrite_i,
   input  logic [`APB_PERIPH_REG_MSB-`APB_PERIPH_REG_LSB:0] reg_idx_i,
   input  apb_periph_pkg::apb_data_t                        wdata_i,
   output apb_periph_pkg::apb_data_t                        rdata_o,
   output logic                                             pwm_en_o,
   output logic [7:0]                                       prescale_o,
   output apb_periph_pkg::pwm_cnt_t                         period_o,
   output apb_periph_pkg::pwm_cnt_t [`APB_PERIPH_PWM_CH-1:0] threshold_o
);

   logic wr_en;

   assign wr_en = sel_i && penable_i && pwrite_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pwm_en_o    <= 1'b0;
         prescale_o  <= '0;
         period_o    <= '0;
         threshold_o <= '0;
      end else if (wr_en) begin
         if (reg_idx_i == 3'd0) begin
            pwm_en_o   <= wdata_i[0];
            prescale_o <= wdata_i[15:8];
         end
         if (reg_idx_i == 3'd1) begin
            period_o <= wdata_i[`APB_PERIPH_PWM_W-1:0];
         end
         // Thresholds from index 2 up
         for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) begin
            if (reg_idx_i == 3'(k + 2)) begin
               threshold_o[k] <= wdata_i[`APB_PERIPH_PWM_W-1:0];
            end
         end
      end
   end

   always_comb begin
      rdata_o = '0;
      case (reg_idx_i)
         3'd0: begin
            rdata_o[0]    = pwm_en_o;
            rdata_o[15:8] = prescale_o;
         end
         3'd1:    rdata_o[`APB_PERIPH_PWM_W-1:0] = period_o;
         3'd2:    rdata_o[`APB_PERIPH_PWM_W-1:0] = threshold_o[0];
         3'd3:    rdata_o[`APB_PERIPH_PWM_W-1:0] = threshold_o[1];
         3'd4:    rdata_o[`APB_PERIPH_PWM_W-1:0] = threshold_o[2];
         3'd5:    rdata_o[`APB_PERIPH_PWM_W-1:0] = threshold_o[3];
         default: rdata_o = '0;
      endcase
   end

endmodule

/* design/pwm_gen.sv */
// Channel outputs are registered and trail the counter by one clock; a period below the count wraps
`include "apb_periph_settings.svh"

module pwm_gen (
   input  logic                                              clk_i,
   input  logic                                              arst_n_i,
   input  logic                                              pwm_en_i,
   input  logic [7:0]                                        prescale_i,
   input  apb_periph_pkg::pwm_cnt_t                          period_i,
   input  apb_periph_pkg::pwm_cnt_t [`APB_PERIPH_PWM_CH-1:0] threshold_i,
   output logic [`APB_PERIPH_PWM_CH-1:0]                     pwm_o
);

   logic [7:0]               pre_q;
   apb_periph_pkg::pwm_cnt_t cnt_q;
   logic                     tick;

   // Also fires if the prescaler is lowered below the running count
   assign tick = (pre_q >= prescale_i);

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pre_q <= '0;
         cnt_q <= '0;
      end else if (!pwm_en_i) begin
         pre_q <= '0;
         cnt_q <= '0;
      end else if (tick) begin
         pre_q <= '0;
         if (cnt_q >= period_i) begin
            cnt_q <= '0;
         end else begin
            cnt_q <= cnt_q + 1'b1;
         end
      end else begin
         pre_q <= pre_q + 1'b1;
      end
   end

   // High while the count is below the threshold
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pwm_o <= '0;
      end else begin
         for (int k = 0; k < `APB_PERIPH_PWM_CH; k++) begin
            pwm_o[k] <= pwm_en_i && (cnt_q < threshold_i[k]);
         end
      end
   end

endmodule

/* design/soc_ctrl_regs.sv */
// Cluster stays in reset until software sets CTRL bit 0; outputs change at the write edge
`include "apb_periph_settings.svh"

module soc_ctrl_regs (
   input  logic                                             clk_i,
   input  logic                                             arst_n_i,
   input  logic                                             sel_i,
   input  logic                                             penable_i,
   input  logic                                             pwrite_i,
   input  logic [`APB_PERIPH_REG_MSB-`APB_PERIPH_REG_LSB:0] reg_idx_i,
   input  apb_periph_pkg::apb_data_t                        wdata_i,
   output apb_periph_pkg::apb_data_t                        rdata_o,
   output logic                                             cluster_rstn_o,
   output logic                                             cluster_en_sa_boot_o,
   output logic                                             cluster_fetch_en_o,
   output apb_periph_pkg::apb_addr_t                        cluster_boot_addr_o
);

   logic       wr_en;
   logic [2:0] ctrl_q;

   assign wr_en = sel_i && penable_i && pwrite_i;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ctrl_q              <= '0;
         cluster_boot_addr_o <= `APB_PERIPH_BOOT_ADDR_RST;
      end else if (wr_en) begin
         if (reg_idx_i == 3'd0) begin
            ctrl_q <= wdata_i[2:0];
         end
         if (reg_idx_i == 3'd1) begin
            cluster_boot_addr_o <= wdata_i;
         end
      end
   end

   // Bit 0 high releases the cluster reset
   assign cluster_rstn_o       = ctrl_q[0];
   assign cluster_en_sa_boot_o = ctrl_q[1];
   assign cluster_fetch_en_o   = ctrl_q[2];

   always_comb begin
      rdata_o = '0;
      case (reg_idx_i)
         3'd0:    rdata_o[2:0] = ctrl_q;
         3'd1:    rdata_o = cluster_boot_addr_o;
         default: rdata_o = '0;
      endcase
   end

endmodule
